// File: compile.f
logic/cache_pkg.sv
logic/lookup_if.sv
logic/tag_array.sv
logic/line_ram.sv
logic/read_return.sv
logic/l1_cache.sv
verif/l1_cache_props.sv
verif/tb_l1_cache.sv

// File: Makefile
# Verilator build and run for the l1_cache testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_l1_cache -f compile.f

run: compile
	./obj_dir/Vtb_l1_cache > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q ">>> FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;
	import cache_pkg::*;

	localparam int          RANDOM_CYCLES   = 2000;
	localparam int          DIRECTED_CYCLES = 400;	// Upper bound of the directed phases
	localparam int          TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 600;
	localparam logic [31:0] SEED            = 32'h903f_b35a;

	logic              iCLOCK;
	logic              inRESET;
	logic              flush;
	logic              rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_valid;
	logic              rd_hit;
	word_t             rd_data;
	logic              wr_req;
	logic [ADDR_W-1:0] wr_addr;
	line_t             wr_line;

	// Reference model state
	logic [TAG_W-1:0]        m_tag  [NUM_SETS][NUM_WAYS];
	line_status_e            m_stat [NUM_SETS][NUM_WAYS];
	line_t                   m_line [NUM_SETS][NUM_WAYS];
	logic [AGE_PERIOD_W-1:0] m_timer;
	logic                    m_hit;
	logic                    m_tick;
	int                      m_way;
	int                      m_victim;
	set_idx_t                rs;
	set_idx_t                ws;
	logic                    exp_valid = 1'b0;
	logic                    exp_hit   = 1'b0;
	word_t                   exp_data  = '0;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	logic [TAG_W-1:0] tag_pool [6] = '{22'h1a5, 22'h2c3, 22'h07f, 22'h3001, 22'h1234, 22'h0bee};
	set_idx_t         set_pool [3] = '{4'd3, 4'd7, 4'd12};

	l1_cache uut (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.flush    (flush),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_valid (rd_valid),
		.rd_hit   (rd_hit),
		.rd_data  (rd_data),
		.wr_req   (wr_req),
		.wr_addr  (wr_addr),
		.wr_line  (wr_line)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
			input set_idx_t set, input word_sel_t word);
		return {tag, set, word, 3'b000};	// tag | set | word | byte
	endfunction

	function automatic word_t line_word(input line_t line, input int w);
		return line[w*WORD_W +: WORD_W];
	endfunction

	function automatic line_t rand_line();
		line_t l;
		for (int i = 0; i < LINE_W/32; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	function automatic logic [ADDR_W-1:0] rand_addr();
		return make_addr(tag_pool[$urandom % 6], set_pool[$urandom % 3], 3'($urandom % 8));
	endfunction

	// Write way by tag match first, then by lowest status, else way 3
	function automatic int choose_way(input set_idx_t s, input logic [TAG_W-1:0] t);
		line_status_e order [3] = '{ST_INVALID, ST_OLD, ST_WARM};
		for (int w = 0; w < NUM_WAYS; w++)
			if (m_tag[s][w] == t)
				return w;
		foreach (order[i])
			for (int w = 0; w < NUM_WAYS; w++)
				if (m_stat[s][w] == order[i])
					return w;
		return NUM_WAYS - 1;
	endfunction

	task automatic apply_cycle(input logic rr, input logic [ADDR_W-1:0] ra, input logic wr,
			input logic [ADDR_W-1:0] wa, input line_t wl, input logic fl);
		@(posedge iCLOCK);
		rd_req  <= rr;
		rd_addr <= ra;
		wr_req  <= wr;
		wr_addr <= wa;
		wr_line <= wl;
		flush   <= fl;
	endtask

	task automatic idle();
		apply_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic write_line(input logic [ADDR_W-1:0] addr, input line_t line);
		apply_cycle(1'b0, '0, 1'b1, addr, line, 1'b0);
	endtask

	// One read with an optional write to the same address at the same edge
	task automatic read_expect(input logic [ADDR_W-1:0] addr, input logic with_wr,
			input line_t wl, input logic hit, input word_t word);
		apply_cycle(1'b1, addr, with_wr, addr, wl, 1'b0);
		idle();
		@(negedge iCLOCK);
		check_value(64'(rd_valid), 64'(1'b1), "directed rd_valid");
		check_value(64'(rd_hit), 64'(hit), "directed rd_hit");
		check_value(rd_data, hit ? word : '0, "directed rd_data");
	endtask

	// Model predicts the read sampled at this edge and then updates
	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			for (int s = 0; s < NUM_SETS; s++)
				for (int w = 0; w < NUM_WAYS; w++) begin
					m_tag[s][w]  = '0;
					m_stat[s][w] = ST_INVALID;
				end
			m_timer   = '0;
			exp_valid = 1'b0;
			exp_hit   = 1'b0;
			exp_data  = '0;
		end else begin
			rs    = rd_addr[9:6];
			ws    = wr_addr[9:6];
			m_hit = 1'b0;
			m_way = 0;
			for (int w = NUM_WAYS-1; w >= 0; w--)	// Lowest matching way wins
				if (m_stat[rs][w] != ST_INVALID && m_tag[rs][w] == rd_addr[31:10]) begin
					m_hit = 1'b1;
					m_way = w;
				end
			exp_valid = rd_req && !flush;
			exp_hit   = exp_valid && m_hit;
			exp_data  = exp_hit ? line_word(m_line[rs][m_way], int'(rd_addr[5:3])) : '0;
			if (flush) begin
				for (int s = 0; s < NUM_SETS; s++)
					for (int w = 0; w < NUM_WAYS; w++)
						m_stat[s][w] = ST_INVALID;
				m_timer = '0;
			end else begin
				m_tick  = (m_timer == '1);
				m_timer = m_timer + 1'b1;
				if (wr_req) begin
					m_victim = choose_way(ws, wr_addr[31:10]);
					m_tag[ws][m_victim]  = wr_addr[31:10];
					m_stat[ws][m_victim] = ST_RECENT;
					m_line[ws][m_victim] = wr_line;
				end else begin
					if (m_tick)
						for (int s = 0; s < NUM_SETS; s++)
							for (int w = 0; w < NUM_WAYS; w++)
								if (m_stat[s][w] == ST_RECENT)
									m_stat[s][w] = ST_WARM;
								else if (m_stat[s][w] == ST_WARM)
									m_stat[s][w] = ST_OLD;
					if (rd_req && m_hit)
						m_stat[rs][m_way] = ST_RECENT;
				end
			end
		end
	end

	always @(negedge iCLOCK) begin	// Outputs settled mid-cycle
		if (inRESET) begin
			check_value(64'(rd_valid), 64'(exp_valid), "rd_valid");
			check_value(64'(rd_hit), 64'(exp_hit), "rd_hit");
			check_value(rd_data, exp_data, "rd_data");
		end
	end

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		line_t lines [5];
		line_t old_line;
		line_t new_line;
		void'($urandom(SEED));
		inRESET = 1'b0;
		flush   = 1'b0;
		rd_req  = 1'b0;
		rd_addr = '0;
		wr_req  = 1'b0;
		wr_addr = '0;
		wr_line = '0;
		repeat (3) @(posedge iCLOCK);
		inRESET <= 1'b1;

		// Empty after reset and after flush
		read_expect(make_addr(22'h0, 4'd1, 3'd0), 1'b0, '0, 1'b0, '0);
		read_expect(make_addr(22'h100, 4'd1, 3'd4), 1'b0, '0, 1'b0, '0);
		write_line(make_addr(22'h100, 4'd1, 3'd0), rand_line());
		apply_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1);
		read_expect(make_addr(22'h100, 4'd1, 3'd4), 1'b0, '0, 1'b0, '0);

		// Every word of a written line
		lines[0] = rand_line();
		write_line(make_addr(22'h150, 4'd2, 3'd0), lines[0]);
		for (int w = 0; w < 8; w++)
			read_expect(make_addr(22'h150, 4'd2, 3'(w)), 1'b0, '0, 1'b1, line_word(lines[0], w));

		// Fifth tag in a full set of recent lines replaces way 3
		for (int i = 0; i < 5; i++) begin
			lines[i] = rand_line();
			write_line(make_addr(22'h200 + 22'(i), 4'd5, 3'd0), lines[i]);
		end
		for (int i = 0; i < 5; i++)
			read_expect(make_addr(22'h200 + 22'(i), 4'd5, 3'd1), 1'b0, '0, i != 3,
				line_word(lines[i], 1));

		// Refreshed line survives while the first unreferenced one is evicted
		for (int i = 0; i < 5; i++)
			lines[i] = rand_line();
		for (int i = 0; i < 4; i++)
			write_line(make_addr(22'h280 + 22'(i), 4'd9, 3'd0), lines[i]);
		repeat (140)
			apply_cycle(1'b1, make_addr(22'h280, 4'd9, 3'd0), 1'b0, '0, '0, 1'b0);
		write_line(make_addr(22'h284, 4'd9, 3'd0), lines[4]);
		for (int i = 0; i < 5; i++)
			read_expect(make_addr(22'h280 + 22'(i), 4'd9, 3'd6), 1'b0, '0, i != 1,
				line_word(lines[i], 6));

		// Same-edge read and write see the prior contents
		old_line = rand_line();
		new_line = rand_line();
		write_line(make_addr(22'h300, 4'd11, 3'd0), old_line);
		read_expect(make_addr(22'h300, 4'd11, 3'd2), 1'b1, new_line, 1'b1,
			line_word(old_line, 2));
		read_expect(make_addr(22'h300, 4'd11, 3'd2), 1'b0, '0, 1'b1, line_word(new_line, 2));
		read_expect(make_addr(22'h301, 4'd11, 3'd5), 1'b1, old_line, 1'b0, '0);
		read_expect(make_addr(22'h301, 4'd11, 3'd5), 1'b0, '0, 1'b1, line_word(old_line, 5));

		repeat (RANDOM_CYCLES)
			apply_cycle(1'($urandom % 2), rand_addr(), $urandom % 3 == 0, rand_addr(),
				rand_line(), $urandom % 200 == 0);
		idle();
		repeat (3) @(posedge iCLOCK);

		$display("Run finished: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: verif/l1_cache_props.sv
`timescale 1ns/1ps

// Output rules of the read return path
module l1_cache_props (
	input logic             iCLOCK,
	input logic             inRESET,
	input logic             flush,
	input logic             rd_valid,
	input logic             rd_hit,
	input cache_pkg::word_t rd_data
);

	hit_needs_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> rd_valid)
		else $error("rd_hit high while rd_valid is low");

	miss_data_zero: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!rd_hit |-> rd_data == '0)
		else $error("rd_data not zero without a hit");

	// Read strobe is dropped at a flush edge
	flush_drops_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		flush |=> !rd_valid)
		else $error("rd_valid high in the cycle after a flush");

endmodule

bind l1_cache l1_cache_props u_props (.*);

// File: logic/l1_cache.sv
`timescale 1ns/1ps

// Four-way, sixteen-set data cache with 64-byte lines
module l1_cache (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic                         flush,
	// Read lookup
	input  logic                         rd_req,
	input  logic [cache_pkg::ADDR_W-1:0] rd_addr,
	output logic                         rd_valid,
	output logic                         rd_hit,
	output cache_pkg::word_t             rd_data,
	// Full line write
	input  logic                         wr_req,
	input  logic [cache_pkg::ADDR_W-1:0] wr_addr,
	input  cache_pkg::line_t             wr_line
);
	import cache_pkg::*;

	lookup_if lookup ();

	logic [NUM_WAYS-1:0] way_wr_en;
	set_idx_t            rd_set;
	set_idx_t            wr_set;
	line_t               way_lines [NUM_WAYS];

	assign rd_set = set_of(rd_addr);
	assign wr_set = set_of(wr_addr);

	tag_array u_tag_array (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.rd_addr   (rd_addr),
		.wr_addr   (wr_addr),
		.way_wr_en (way_wr_en),
		.lookup    (lookup.producer)
	);

	// All ways read the same set, only the chosen way writes
	generate
		for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
			line_ram u_line_ram (
				.iCLOCK  (iCLOCK),
				.wr_en   (way_wr_en[w]),
				.wr_set  (wr_set),
				.rd_set  (rd_set),
				.wr_line (wr_line),
				.rd_line (way_lines[w])
			);
		end
	endgenerate

	read_return u_read_return (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.lookup    (lookup.consumer),
		.way_lines (way_lines),
		.rd_valid  (rd_valid),
		.rd_hit    (rd_hit),
		.rd_data   (rd_data)
	);

endmodule

// File: logic/read_return.sv
`timescale 1ns/1ps

module read_return (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic                flush,
	lookup_if.consumer          lookup,
	input  cache_pkg::line_t    way_lines [cache_pkg::NUM_WAYS],
	output logic                rd_valid,
	output logic                rd_hit,
	output cache_pkg::word_t    rd_data
);
	import cache_pkg::*;

	logic      req_q;
	logic      hit_q;
	way_idx_t  way_q;
	word_sel_t word_q;
	line_t     sel_line;

	// Lookup result lines up with the RAM read data
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_q  <= 1'b0;
			hit_q  <= 1'b0;
			way_q  <= '0;
			word_q <= '0;
		end else begin
			req_q  <= flush ? 1'b0 : lookup.req;
			hit_q  <= lookup.hit;
			way_q  <= lookup.way;
			word_q <= lookup.word;
		end
	end

	assign sel_line = way_lines[way_q];

	assign rd_valid = req_q;
	assign rd_hit   = req_q && hit_q;
	assign rd_data  = rd_hit ? sel_line[word_q*WORD_W +: WORD_W] : '0;	// Zero on miss

endmodule

// File: logic/line_ram.sv
`timescale 1ns/1ps

// One way's data store, one write and one registered read port
module line_ram (
	input  logic                iCLOCK,
	input  logic                wr_en,
	input  cache_pkg::set_idx_t wr_set,
	input  cache_pkg::set_idx_t rd_set,
	input  cache_pkg::line_t    wr_line,
	output cache_pkg::line_t    rd_line
);
	import cache_pkg::*;

	line_t mem [NUM_SETS];

	always_ff @(posedge iCLOCK) begin
		if (wr_en)
			mem[wr_set] <= wr_line;
		rd_line <= mem[rd_set];	// Same set as a write returns the old line
	end

endmodule

// File: logic/tag_array.sv
`timescale 1ns/1ps

module tag_array (
	input  logic                           iCLOCK,
	input  logic                           inRESET,
	input  logic                           flush,
	input  logic                           rd_req,
	input  logic                           wr_req,
	input  logic [cache_pkg::ADDR_W-1:0]   rd_addr,
	input  logic [cache_pkg::ADDR_W-1:0]   wr_addr,
	output logic [cache_pkg::NUM_WAYS-1:0] way_wr_en,
	lookup_if.producer                     lookup
);
	import cache_pkg::*;

	addr_tag_t    tags   [NUM_SETS][NUM_WAYS];
	line_status_e status [NUM_SETS][NUM_WAYS];
	logic [AGE_PERIOD_W-1:0] age_timer;

	addr_tag_t rd_tag;
	addr_tag_t wr_tag;
	set_idx_t  rd_set;
	set_idx_t  wr_set;
	logic      rd_hit;
	way_idx_t  rd_way;
	logic      wr_found;
	way_idx_t  wr_way;
	logic      age_tick;

	// One step down the recency ladder, OLD and INVALID stay put
	function automatic line_status_e aged(input line_status_e st);
		case (st)
			ST_RECENT: return ST_WARM;
			ST_WARM:   return ST_OLD;
			default:   return st;
		endcase
	endfunction

	assign rd_tag   = tag_of(rd_addr);
	assign rd_set   = set_of(rd_addr);
	assign wr_tag   = tag_of(wr_addr);
	assign wr_set   = set_of(wr_addr);
	assign age_tick = &age_timer;

	// Hit check on the read set
	always_comb begin
		rd_hit = 1'b0;
		rd_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!rd_hit && status[rd_set][w] != ST_INVALID &&
					tags[rd_set][w] == rd_tag) begin
				rd_hit = 1'b1;
				rd_way = way_idx_t'(w);
			end
		end
	end

	// Victim choice: tag match, then lowest status, else the last way
	always_comb begin
		wr_found = 1'b0;
		wr_way   = way_idx_t'(NUM_WAYS-1);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!wr_found && tags[wr_set][w] == wr_tag) begin	// Valid or not
				wr_found = 1'b1;
				wr_way   = way_idx_t'(w);
			end
		end
		for (int lvl = 0; lvl < 3; lvl++) begin	// INVALID, OLD, WARM
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (!wr_found && status[wr_set][w] == line_status_e'(lvl)) begin
					wr_found = 1'b1;
					wr_way   = way_idx_t'(w);
				end
			end
		end
	end

	always_comb begin
		way_wr_en = '0;
		if (wr_req && !flush)
			way_wr_en[wr_way] = 1'b1;
	end

	assign lookup.req  = rd_req && !flush;
	assign lookup.hit  = rd_hit;
	assign lookup.way  = rd_way;
	assign lookup.word = word_of(rd_addr);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					tags[s][w]   <= '0;
					status[s][w] <= ST_INVALID;
				end
			end
			age_timer <= '0;
		end else if (flush) begin
			// Tags survive, every line goes invalid
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++)
					status[s][w] <= ST_INVALID;
			end
			age_timer <= '0;
		end else begin
			age_timer <= age_timer + 1'b1;
			if (wr_req) begin	// Write wins over aging and refresh
				tags[wr_set][wr_way]   <= wr_tag;
				status[wr_set][wr_way] <= ST_RECENT;
			end else begin
				if (age_tick) begin
					for (int s = 0; s < NUM_SETS; s++) begin
						for (int w = 0; w < NUM_WAYS; w++)
							status[s][w] <= aged(status[s][w]);
					end
				end
				// Later assignment overrides aging of the hit line
				if (rd_req && rd_hit)
					status[rd_set][rd_way] <= ST_RECENT;
			end
		end
	end

endmodule

// File: logic/lookup_if.sv
`timescale 1ns/1ps

// One cycle's read lookup, from the tag array to the return stage
interface lookup_if;
	import cache_pkg::*;

	logic      req;		// Read strobe, low during flush
	logic      hit;
	way_idx_t  way;		// Hit way, first match wins
	word_sel_t word;	// 64-bit word within the line

	modport producer (
		output req, hit, way, word
	);

	modport consumer (
		input req, hit, way, word
	);

endinterface

// File: logic/cache_pkg.sv
package cache_pkg;

	// Geometry
	localparam int ADDR_W       = 32;
	localparam int NUM_WAYS     = 4;
	localparam int NUM_SETS     = 16;
	localparam int LINE_W       = 512;
	localparam int WORD_W       = 64;
	localparam int TAG_W        = 22;
	localparam int SET_W        = 4;
	localparam int WORD_SEL_W   = 3;	// Address bits 5 to 3
	localparam int AGE_PERIOD_W = 6;	// Short so aging ticks come often

	typedef logic [TAG_W-1:0]              addr_tag_t;
	typedef logic [SET_W-1:0]              set_idx_t;
	typedef logic [$clog2(NUM_WAYS)-1:0]   way_idx_t;
	typedef logic [WORD_SEL_W-1:0]         word_sel_t;
	typedef logic [LINE_W-1:0]             line_t;
	typedef logic [WORD_W-1:0]             word_t;

	// Recency status, higher is more recent
	typedef enum logic [1:0] {
		ST_INVALID = 2'd0,
		ST_OLD     = 2'd1,
		ST_WARM    = 2'd2,
		ST_RECENT  = 2'd3
	} line_status_e;

	// Address fields: tag | set | word | byte
	function automatic addr_tag_t tag_of(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic set_idx_t set_of(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-TAG_W-1 -: SET_W];
	endfunction

	function automatic word_sel_t word_of(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-TAG_W-SET_W-1 -: WORD_SEL_W];
	endfunction

endpackage
